// File: hdl/aqed_flow_cam_config.svh
`ifndef AQED_FLOW_CAM_CONFIG_SVH
`define AQED_FLOW_CAM_CONFIG_SVH

// bank partitioning of the flow id space
`define AQED_NUM_BANKS 4
`define AQED_BANK_BITS 2

// entries held by each bank CAM
`define AQED_BANK_ENTRIES 32
`define AQED_ENTRY_BITS 5

// every entry gets one invalidating write after reset
`define AQED_INIT_CYCLES `AQED_BANK_ENTRIES

`endif

// File: hdl/aqed_types_pkg.sv
`default_nettype none

`include "aqed_flow_cam_config.svh"

package aqed_types_pkg;

  typedef logic [6:0]                                     qid_t;
  typedef logic [15:0]                                    hid_t;
  typedef logic [`AQED_ENTRY_BITS-1:0]                    entry_t;
  typedef logic [`AQED_BANK_BITS-1:0]                     bank_t;
  // bank index sits above the entry index
  typedef logic [`AQED_BANK_BITS+`AQED_ENTRY_BITS-1:0]    fid_t;
  typedef logic [`AQED_BANK_ENTRIES-1:0]                  match_t;

  typedef enum logic [1:0] {
    op_ill     = 2'd0,
    op_lookup  = 2'd1,
    op_enq_wen = 2'd2,
    op_cmp_wen = 2'd3
  } aqed_op_e;

  typedef struct packed {
    aqed_op_e op;
    fid_t     fid;
    qid_t     qid;
    hid_t     hid;
  } aqed_req_t;

  typedef struct packed {
    aqed_op_e op;
    fid_t     fid;
    qid_t     qid;
    hid_t     hid;
    logic     hit;
    logic     vac;
  } aqed_rsp_t;

  typedef struct packed {
    logic double_hit;
    logic cmp_unset;
  } aqed_err_t;

  // cam key and stored entry
  typedef struct packed {
    qid_t qid;
    hid_t hid;
  } cam_key_t;

  typedef struct packed {
    logic     valid;
    cam_key_t key;
  } cam_entry_t;

endpackage

`default_nettype wire

// File: hdl/aqed_csr_pkg.sv
`default_nettype none

package aqed_csr_pkg;

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // register map
  localparam apb_addr_t reg_status   = 8'h00;
  localparam apb_addr_t reg_err      = 8'h04;
  localparam apb_addr_t reg_hit_cnt  = 8'h08;
  localparam apb_addr_t reg_miss_cnt = 8'h0C;

  // field positions
  localparam int unsigned status_init_bit     = 0;
  localparam int unsigned status_notempty_lsb = 4;
  localparam int unsigned err_double_hit_bit  = 0;
  localparam int unsigned err_cmp_unset_bit   = 1;

endpackage

`default_nettype wire

// File: hdl/aqed_bcam_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "aqed_flow_cam_config.svh"

module aqed_bcam_array
  import aqed_types_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       cam_wen,
  input  wire entry_t     cam_waddr,
  input  wire cam_entry_t cam_wdata,
  input  wire logic       cam_cen,
  input  wire cam_key_t   cam_ckey,
  output match_t          cam_match
);

  cam_entry_t mem [`AQED_BANK_ENTRIES];
  match_t     match_c;

  // single write port
  always_ff @(posedge clk) begin
    if (cam_wen) begin
      mem[cam_waddr] <= cam_wdata;
    end
  end

  // one comparator per entry, qualified by the stored valid bit
  always_comb begin
    for (int i = 0; i < `AQED_BANK_ENTRIES; i++) begin
      match_c[i] = mem[i].valid && (mem[i].key == cam_ckey);
    end
  end

  // match vector holds until the next compare
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cam_match <= '0;
    end else if (cam_cen) begin
      cam_match <= match_c;
    end
  end

endmodule

`default_nettype wire

// File: hdl/aqed_bcam_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "aqed_flow_cam_config.svh"

module aqed_bcam_core
  import aqed_types_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire bank_t     bank_id,
  input  wire logic      in_valid,
  input  wire aqed_req_t in_req,
  output logic           cam_wen,
  output entry_t         cam_waddr,
  output cam_entry_t     cam_wdata,
  output logic           cam_cen,
  output cam_key_t       cam_ckey,
  input  wire match_t    cam_match,
  output logic           out_valid,
  output aqed_rsp_t      out_rsp,
  output aqed_err_t      err,
  output logic           notempty,
  output logic           init_active
);

  typedef enum logic {
    st_init,
    st_run
  } init_state_e;

  init_state_e state;
  entry_t      init_cnt;
  match_t      vld_f;
  logic        p0_v;
  logic        p1_v;
  logic        p2_v;
  aqed_req_t   p0_req;
  aqed_req_t   p1_req;
  aqed_req_t   p2_req;
  match_t      hitv_f;
  logic        dbl_f;
  entry_t      p0_entry;
  logic        p0_lookup;
  logic        p0_enq;
  logic        p0_cmp;
  logic        hit;

  // priority encoder, lowest index wins
  function automatic entry_t lowest_set(input match_t v);
    entry_t idx;
    idx = '0;
    for (int i = `AQED_BANK_ENTRIES - 1; i >= 0; i--) begin
      if (v[i]) begin
        idx = entry_t'(i);
      end
    end
    return idx;
  endfunction

  // init sweep, one entry per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_init;
      init_cnt <= '0;
    end else if (state == st_init) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == entry_t'(`AQED_INIT_CYCLES - 1)) begin
        state <= st_run;
      end
    end
  end

  assign init_active = (state == st_init);

  assign p0_entry  = p0_req.fid[`AQED_ENTRY_BITS-1:0];
  assign p0_lookup = p0_v && (p0_req.op == op_lookup);
  assign p0_enq    = p0_v && (p0_req.op == op_enq_wen);
  assign p0_cmp    = p0_v && (p0_req.op == op_cmp_wen);

  // only lookups travel past p0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p0_v  <= 1'b0;
      p1_v  <= 1'b0;
      p2_v  <= 1'b0;
      vld_f <= '0;
    end else begin
      p0_v <= in_valid && (state == st_run);
      p1_v <= p0_lookup;
      p2_v <= p1_v;
      if (p0_enq) begin
        vld_f[p0_entry] <= 1'b1;
      end
      if (p0_cmp) begin
        vld_f[p0_entry] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      p0_req <= in_req;
    end
    if (p0_lookup) begin
      p1_req <= p0_req;
    end
    // match vector arrives with p1
    if (p1_v) begin
      p2_req <= p1_req;
      hitv_f <= cam_match;
      dbl_f  <= |(cam_match & (cam_match - 1'b1));
    end
  end

  // the init sweep owns the write port until it finishes
  always_comb begin
    cam_wen             = p0_enq || p0_cmp;
    cam_waddr           = p0_entry;
    cam_wdata.valid     = p0_enq;
    cam_wdata.key.qid   = p0_req.qid;
    cam_wdata.key.hid   = p0_req.hid;
    if (state == st_init) begin
      cam_wen   = 1'b1;
      cam_waddr = init_cnt;
      cam_wdata = '0;
    end
  end

  assign cam_cen      = p0_lookup;
  assign cam_ckey.qid = p0_req.qid;
  assign cam_ckey.hid = p0_req.hid;

  // p2 result: hit index or allocation candidate
  always_comb begin
    hit         = |hitv_f;
    out_valid   = p2_v;
    out_rsp.op  = p2_req.op;
    out_rsp.qid = p2_req.qid;
    out_rsp.hid = p2_req.hid;
    out_rsp.hit = hit;
    out_rsp.vac = |(~vld_f);
    if (hit) begin
      out_rsp.fid = {bank_id, lowest_set(hitv_f)};
    end else begin
      out_rsp.fid = {bank_id, lowest_set(~vld_f)};
    end
  end

  always_comb begin
    err.double_hit = p2_v && dbl_f;
    err.cmp_unset  = p0_cmp && !vld_f[p0_entry];
  end

  assign notempty = |vld_f;

endmodule

`default_nettype wire

// File: hdl/aqed_req_steer.sv
`timescale 1ns/1ns
`default_nettype none

`include "aqed_flow_cam_config.svh"

module aqed_req_steer
  import aqed_types_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 req_valid,
  input  wire aqed_req_t            req,
  output logic [`AQED_NUM_BANKS-1:0] bank_valid,
  output aqed_req_t                 bank_req
);

  bank_t tgt_bank;

  // lookups hash the key, writes already carry their bank in the fid
  always_comb begin
    if (req.op == op_lookup) begin
      tgt_bank = req.hid[`AQED_BANK_BITS-1:0] ^ req.qid[`AQED_BANK_BITS-1:0];
    end else begin
      tgt_bank = req.fid[`AQED_BANK_BITS+`AQED_ENTRY_BITS-1:`AQED_ENTRY_BITS];
    end
  end

  // one-hot bank select, illegal ops dropped here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bank_valid <= '0;
    end else begin
      bank_valid <= '0;
      if (req_valid && (req.op != op_ill)) begin
        bank_valid[tgt_bank] <= 1'b1;
      end
    end
  end

  // request shared by all banks
  always_ff @(posedge clk) begin
    if (req_valid) begin
      bank_req <= req;
    end
  end

endmodule

`default_nettype wire

// File: hdl/aqed_rsp_merge.sv
`timescale 1ns/1ns
`default_nettype none

`include "aqed_flow_cam_config.svh"

module aqed_rsp_merge
  import aqed_types_pkg::*;
(
  input  wire logic [`AQED_NUM_BANKS-1:0] bank_out_valid,
  input  wire aqed_rsp_t                  bank_rsp [`AQED_NUM_BANKS],
  input  wire aqed_err_t                  bank_err [`AQED_NUM_BANKS],
  input  wire logic [`AQED_NUM_BANKS-1:0] bank_notempty,
  input  wire logic [`AQED_NUM_BANKS-1:0] bank_init,
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  output logic                            rsp_valid,
  output aqed_rsp_t                       rsp,
  output aqed_err_t                       err_pulse,
  output logic [`AQED_NUM_BANKS-1:0]      notempty,
  output logic                            init_active
);

  aqed_rsp_t sel_rsp;

  // banks share one latency so at most one is valid per cycle
  always_comb begin
    sel_rsp   = bank_rsp[0];
    err_pulse = '0;
    for (int b = 0; b < `AQED_NUM_BANKS; b++) begin
      if (bank_out_valid[b]) begin
        sel_rsp = bank_rsp[b];
      end
      err_pulse = err_pulse | bank_err[b];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= |bank_out_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (|bank_out_valid) begin
      rsp <= sel_rsp;
    end
  end

  // status goes straight to the CSR block
  assign notempty    = bank_notempty;
  assign init_active = |bank_init;

endmodule

`default_nettype wire

// File: hdl/aqed_csr_apb.sv
`timescale 1ns/1ns
`default_nettype none

`include "aqed_flow_cam_config.svh"

module aqed_csr_apb
  import aqed_types_pkg::*;
  import aqed_csr_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire apb_req_t                   apb_req,
  output apb_rsp_t                        apb_rsp,
  input  wire logic                       rsp_valid,
  input  wire logic                       rsp_hit,
  input  wire aqed_err_t                  err_pulse,
  input  wire logic [`AQED_NUM_BANKS-1:0] notempty,
  input  wire logic                       init_active
);

  typedef enum logic {
    apb_idle,
    apb_access
  } apb_state_e;

  apb_state_e                  state;
  logic                        access;
  logic                        wr_en;
  logic                        addr_ok;
  logic [31:0]                 rdata;
  logic [$bits(aqed_err_t)-1:0] err_q;
  logic [$bits(aqed_err_t)-1:0] err_set;
  logic [$bits(aqed_err_t)-1:0] err_clr;
  logic [31:0]                 hit_cnt;
  logic [31:0]                 miss_cnt;

  // setup phase moves to access, access always returns to idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= apb_idle;
    end else if (state == apb_idle) begin
      if (apb_req.psel && !apb_req.penable) begin
        state <= apb_access;
      end
    end else begin
      state <= apb_idle;
    end
  end

  assign access = (state == apb_access) && apb_req.psel && apb_req.penable;
  assign wr_en  = access && apb_req.pwrite;

  always_comb begin
    rdata   = '0;
    addr_ok = 1'b1;
    case (apb_req.paddr)
      reg_status: begin
        rdata[status_init_bit] = init_active;
        rdata[status_notempty_lsb +: `AQED_NUM_BANKS] = notempty;
      end
      reg_err:      rdata[$bits(aqed_err_t)-1:0] = err_q;
      reg_hit_cnt:  rdata = hit_cnt;
      reg_miss_cnt: rdata = miss_cnt;
      default:      addr_ok = 1'b0;
    endcase
  end

  // no wait states
  assign apb_rsp.prdata  = access ? rdata : '0;
  assign apb_rsp.pready  = access;
  assign apb_rsp.pslverr = access && !addr_ok;

  // a new error wins over a clear in the same cycle
  always_comb begin
    err_set                     = '0;
    err_set[err_double_hit_bit] = err_pulse.double_hit;
    err_set[err_cmp_unset_bit]  = err_pulse.cmp_unset;
    err_clr                     = '0;
    if (wr_en && (apb_req.paddr == reg_err)) begin
      err_clr = apb_req.pwdata[$bits(aqed_err_t)-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q    <= '0;
      hit_cnt  <= '0;
      miss_cnt <= '0;
    end else begin
      err_q <= (err_q & ~err_clr) | err_set;
      // only lookups produce responses
      if (rsp_valid && rsp_hit) begin
        hit_cnt <= hit_cnt + 1'b1;
      end
      if (rsp_valid && !rsp_hit) begin
        miss_cnt <= miss_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/aqed_flow_cam_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "aqed_flow_cam_config.svh"

module aqed_flow_cam_top
  import aqed_types_pkg::*;
  import aqed_csr_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      req_valid,
  input  wire aqed_req_t req,
  output wire logic      rsp_valid,
  output wire aqed_rsp_t rsp,
  output wire logic      init_active,
  input  wire apb_req_t  apb_req,
  output wire apb_rsp_t  apb_rsp
);

  wire logic [`AQED_NUM_BANKS-1:0] bank_valid;
  wire aqed_req_t                  bank_req;
  wire logic [`AQED_NUM_BANKS-1:0] core_valid;
  wire logic [`AQED_NUM_BANKS-1:0] core_notempty;
  wire logic [`AQED_NUM_BANKS-1:0] core_init;
  wire aqed_rsp_t                  core_rsp [`AQED_NUM_BANKS];
  wire aqed_err_t                  core_err [`AQED_NUM_BANKS];
  wire aqed_err_t                  err_pulse;
  wire logic [`AQED_NUM_BANKS-1:0] bank_notempty;

  aqed_req_steer steer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .bank_valid (bank_valid),
    .bank_req   (bank_req)
  );

  // one CAM array and core per bank
  for (genvar b = 0; b < `AQED_NUM_BANKS; b++) begin : g_bank
    wire logic       cam_wen;
    wire entry_t     cam_waddr;
    wire cam_entry_t cam_wdata;
    wire logic       cam_cen;
    wire cam_key_t   cam_ckey;
    wire match_t     cam_match;

    aqed_bcam_array array_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cam_wen   (cam_wen),
      .cam_waddr (cam_waddr),
      .cam_wdata (cam_wdata),
      .cam_cen   (cam_cen),
      .cam_ckey  (cam_ckey),
      .cam_match (cam_match)
    );

    aqed_bcam_core core_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .bank_id     (bank_t'(b)),
      .in_valid    (bank_valid[b]),
      .in_req      (bank_req),
      .cam_wen     (cam_wen),
      .cam_waddr   (cam_waddr),
      .cam_wdata   (cam_wdata),
      .cam_cen     (cam_cen),
      .cam_ckey    (cam_ckey),
      .cam_match   (cam_match),
      .out_valid   (core_valid[b]),
      .out_rsp     (core_rsp[b]),
      .err         (core_err[b]),
      .notempty    (core_notempty[b]),
      .init_active (core_init[b])
    );
  end

  aqed_rsp_merge merge_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .bank_out_valid (core_valid),
    .bank_rsp       (core_rsp),
    .bank_err       (core_err),
    .bank_notempty  (core_notempty),
    .bank_init      (core_init),
    .rsp_valid      (rsp_valid),
    .rsp            (rsp),
    .err_pulse      (err_pulse),
    .notempty       (bank_notempty),
    .init_active    (init_active)
  );

  aqed_csr_apb csr_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .rsp_valid   (rsp_valid),
    .rsp_hit     (rsp.hit),
    .err_pulse   (err_pulse),
    .notempty    (bank_notempty),
    .init_active (init_active)
  );

endmodule

`default_nettype wire

// File: testbench/aqed_flow_cam_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "aqed_flow_cam_config.svh"

module aqed_flow_cam_tb
  import aqed_types_pkg::*;
  import aqed_csr_pkg::*;
();

  localparam int rsp_lat    = 5;
  localparam int init_limit = 2 * `AQED_INIT_CYCLES + 16;
  localparam int apb_limit  = 8;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  aqed_req_t req;
  wire logic      rsp_valid;
  wire aqed_rsp_t rsp;
  wire logic      init_active;
  apb_req_t  apb_req;
  wire apb_rsp_t  apb_rsp;

  // expected response travels alongside the lookup it belongs to
  aqed_rsp_t             exp_now;
  aqed_rsp_t [4:0]       exp_d  = '0;
  logic [4:0]            fire_d = '0;
  wire logic             lookup_fire;
  logic [31:0]           lfsr_state;
  int                    hit_total;
  int                    miss_total;

  // reference model of every bank
  bit   model_vld [`AQED_NUM_BANKS][`AQED_BANK_ENTRIES];
  qid_t model_qid [`AQED_NUM_BANKS][`AQED_BANK_ENTRIES];
  hid_t model_hid [`AQED_NUM_BANKS][`AQED_BANK_ENTRIES];

  aqed_flow_cam_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req         (req),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp),
    .init_active (init_active),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  assign lookup_fire = req_valid && (req.op == op_lookup) && !init_active;

  always @(posedge clk) begin
    fire_d <= {fire_d[3:0], lookup_fire};
    exp_d  <= {exp_d[3:0], exp_now};
  end

  task automatic stop_on_error();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  rsp_timing: assert property (@(posedge clk) disable iff (!rst_n) rsp_valid == fire_d[4])
    else begin
      $display("[ERROR] rsp_valid got %h expected %h", $sampled(rsp_valid), $sampled(fire_d[4]));
      stop_on_error();
    end

  rsp_value: assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |-> rsp == exp_d[4])
    else begin
      $display("[ERROR] rsp got %h expected %h", $sampled(rsp), $sampled(exp_d[4]));
      stop_on_error();
    end

  init_quiet: assert property (@(posedge clk) disable iff (!rst_n) init_active |-> !rsp_valid)
    else begin
      $display("[ERROR] rsp_valid got %h expected %h during init", $sampled(rsp_valid), 1'b0);
      stop_on_error();
    end

  // reset release starts the init sweep
  init_start: assert property (@(posedge clk) $rose(rst_n) |-> init_active)
    else begin
      $display("[ERROR] init_active got %h expected %h", $sampled(init_active), 1'b1);
      stop_on_error();
    end

  // pready exactly in the access phase
  apb_ready: assert property (@(posedge clk) disable iff (!rst_n)
    apb_rsp.pready == (apb_req.psel && apb_req.penable))
    else begin
      $display("[ERROR] pready got %h expected %h", $sampled(apb_rsp.pready),
               $sampled(apb_req.psel && apb_req.penable));
      stop_on_error();
    end

  // galois lfsr stepped once per bit
  function automatic logic lfsr_step();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  function automatic bit key_present(input bank_t b, input qid_t q, input hid_t h);
    for (int e = 0; e < `AQED_BANK_ENTRIES; e++) begin
      if (model_vld[b][e] && model_qid[b][e] == q && model_hid[b][e] == h) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // random key that hashes to bank b and is not stored there
  task automatic fresh_key(input bank_t b, output qid_t q, output hid_t h);
    int tries;
    tries = 0;
    do begin
      if (tries == 8) begin
        $display("no unused key found for bank %0d after 8 draws", b);
        stop_on_error();
      end
      q = qid_t'(rand_bits(7));
      h = hid_t'(rand_bits(16));
      h[`AQED_BANK_BITS-1:0] = b ^ q[`AQED_BANK_BITS-1:0];
      tries++;
    end while (key_present(b, q, h));
  endtask

  task automatic drive_req(input aqed_op_e op, input fid_t fid, input qid_t q, input hid_t h,
                           input aqed_rsp_t exp);
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= '{op: op, fid: fid, qid: q, hid: h};
    exp_now   <= exp;
  endtask

  task automatic idle(input int cycles);
    @(posedge clk);
    req_valid <= 1'b0;
    repeat (cycles - 1) @(posedge clk);
  endtask

  task automatic write_entry(input aqed_op_e op, input fid_t fid, input qid_t q, input hid_t h);
    bank_t  b;
    entry_t e;
    b = fid[`AQED_BANK_BITS+`AQED_ENTRY_BITS-1:`AQED_ENTRY_BITS];
    e = fid[`AQED_ENTRY_BITS-1:0];
    model_vld[b][e] = (op == op_enq_wen);
    if (op == op_enq_wen) begin
      model_qid[b][e] = q;
      model_hid[b][e] = h;
    end
    drive_req(op, fid, q, h, '0);
  endtask

  // lowest matching entry on a hit and lowest free entry on a miss
  task automatic lookup_key(input qid_t q, input hid_t h);
    aqed_rsp_t exp;
    bank_t     b;
    int        hit_idx;
    int        free_idx;
    b        = h[`AQED_BANK_BITS-1:0] ^ q[`AQED_BANK_BITS-1:0];
    hit_idx  = -1;
    free_idx = -1;
    for (int e = `AQED_BANK_ENTRIES - 1; e >= 0; e--) begin
      if (model_vld[b][e] && model_qid[b][e] == q && model_hid[b][e] == h) begin
        hit_idx = e;
      end
      if (!model_vld[b][e]) begin
        free_idx = e;
      end
    end
    exp.op  = op_lookup;
    exp.qid = q;
    exp.hid = h;
    exp.hit = (hit_idx >= 0);
    exp.vac = (free_idx >= 0);
    if (exp.hit) begin
      exp.fid = {b, entry_t'(hit_idx)};
      hit_total++;
    end else begin
      exp.fid = {b, entry_t'((free_idx < 0) ? 0 : free_idx)};
      miss_total++;
    end
    drive_req(op_lookup, '0, q, h, exp);
  endtask

  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic slverr);
    int n;
    n = 0;
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready) begin
      if (n == apb_limit) begin
        $display("APB access to 0x%h got no pready within %0d cycles", addr, apb_limit);
        stop_on_error();
      end
      n++;
      @(negedge clk);
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic check_reg(input apb_addr_t addr, input apb_data_t exp, input string name);
    apb_data_t data;
    logic      slverr;
    apb_xfer(1'b0, addr, '0, data, slverr);
    assert (data == exp) else begin
      $display("[ERROR] %s got %h expected %h", name, data, exp);
      stop_on_error();
    end
    assert (!slverr) else begin
      $display("[ERROR] pslverr on %s got %h expected %h", name, slverr, 1'b0);
      stop_on_error();
    end
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t wdata);
    apb_data_t data;
    logic      slverr;
    apb_xfer(1'b1, addr, wdata, data, slverr);
    assert (!slverr) else begin
      $display("[ERROR] pslverr on write to 0x%h got %h expected %h", addr, slverr, 1'b0);
      stop_on_error();
    end
  endtask

  task automatic wait_init_done();
    int n;
    n = 0;
    @(negedge clk);
    while (init_active) begin
      if (n == init_limit) begin
        $display("init_active did not fall within %0d cycles", init_limit);
        stop_on_error();
      end
      n++;
      @(negedge clk);
    end
  endtask

  initial begin
    qid_t      q;
    hid_t      h;
    qid_t      kq;
    hid_t      kh;
    apb_data_t data;
    logic      slverr;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    apb_req    = '0;
    exp_now    = '0;
    lfsr_state = 32'h60916789;
    hit_total  = 0;
    miss_total = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // requests sent during the init sweep are dropped
    check_reg(reg_status, 32'h1, "reg_status");
    drive_req(op_enq_wen, '0, 7'h11, 16'h2222, '0);
    drive_req(op_lookup, '0, 7'h11, 16'h2222, '0);
    idle(1);
    wait_init_done();
    check_reg(reg_status, 32'h0, "reg_status");
    check_reg(reg_err, 32'h0, "reg_err");

    // miss then enqueue and hit on the next cycle
    fresh_key(2'd1, q, h);
    lookup_key(q, h);
    idle(rsp_lat + 1);
    write_entry(op_enq_wen, {2'd1, 5'd0}, q, h);
    lookup_key(q, h);
    idle(rsp_lat + 1);

    // fill bank 2 completely
    for (int e = 0; e < `AQED_BANK_ENTRIES; e++) begin
      fresh_key(2'd2, q, h);
      write_entry(op_enq_wen, {2'd2, entry_t'(e)}, q, h);
      if (e == 17) begin
        kq = q;
        kh = h;
      end
    end
    lookup_key(kq, kh);
    fresh_key(2'd2, q, h);
    lookup_key(q, h);
    idle(rsp_lat + 1);
    check_reg(reg_status, 32'h60, "reg_status");

    // complete frees entry 5 before a complete to an empty entry
    write_entry(op_cmp_wen, {2'd2, 5'd5}, '0, '0);
    fresh_key(2'd2, q, h);
    lookup_key(q, h);
    idle(rsp_lat + 1);
    check_reg(reg_err, 32'h0, "reg_err");
    write_entry(op_cmp_wen, {2'd3, 5'd7}, '0, '0);
    idle(rsp_lat + 1);
    check_reg(reg_err, 32'h2, "reg_err");
    write_reg(reg_err, 32'h3);
    check_reg(reg_err, 32'h0, "reg_err");

    // same key in two entries of bank 0
    fresh_key(2'd0, q, h);
    write_entry(op_enq_wen, {2'd0, 5'd9}, q, h);
    write_entry(op_enq_wen, {2'd0, 5'd3}, q, h);
    lookup_key(q, h);
    idle(rsp_lat + 1);
    check_reg(reg_err, 32'h1, "reg_err");
    write_reg(reg_err, 32'h1);
    check_reg(reg_err, 32'h0, "reg_err");

    // back to back lookups with mixed hits and misses
    for (int i = 0; i < 8; i++) begin
      if (rand_bits(1) == 1) begin
        lookup_key(kq, kh);
      end else begin
        fresh_key(bank_t'(rand_bits(2)), q, h);
        lookup_key(q, h);
      end
    end
    idle(rsp_lat + 1);

    check_reg(reg_hit_cnt, apb_data_t'(hit_total), "reg_hit_cnt");
    check_reg(reg_miss_cnt, apb_data_t'(miss_total), "reg_miss_cnt");
    apb_xfer(1'b0, 8'h10, '0, data, slverr);
    assert (slverr) else begin
      $display("[ERROR] pslverr at offset 10 got %h expected %h", slverr, 1'b1);
      stop_on_error();
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: aqed_flow_cam.f
+incdir+hdl
hdl/aqed_types_pkg.sv
hdl/aqed_csr_pkg.sv
hdl/aqed_bcam_array.sv
hdl/aqed_bcam_core.sv
hdl/aqed_req_steer.sv
hdl/aqed_rsp_merge.sv
hdl/aqed_csr_apb.sv
hdl/aqed_flow_cam_top.sv
testbench/aqed_flow_cam_tb.sv
